/* Makefile */
# Verilator flow for the SPI register peripheral

VERILATOR ?= verilator
TOP       ?= spi_periph_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

# Static checks over the whole file list
lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# Build, run, and fail unless the pass line shows up
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* bench/spi_periph_checker.sv */
// SPI peripheral checker
// Decodes frames off the pins and compares them with a reference register model
`timescale 1ns/1ps
`include "spi_macros.svh"

module spi_periph_checker
  import spi_pkg::*;
(
  input  logic    i_Clk,
  input  logic    i_rst_n,
  input  logic    i_spi_clk,
  input  logic    i_spi_mosi,
  input  logic    i_spi_miso,
  input  logic    i_spi_cs_n,
  input  byte_t   i_status,
  input  byte_t   i_ctrl,
  input  reg_wr_t i_wr_evt,
  output int      o_frames,          // Frames closed so far
  output int      o_checks,
  output int      o_errors
);

  // Capture on falling SCLK when CPOL and CPHA differ
  localparam logic CAP_INV = (`SPI_MODE == 1) || (`SPI_MODE == 2);
  localparam reg_addr_t STATUS_ADDR = reg_addr_t'(`SPI_STATUS_ADDR);

  string     test_name;              // Set by the bench at each test start
  byte_t     model [`SPI_REG_COUNT];
  reg_wr_t   exp_q [$];              // Write events still owed by the DUT
  logic      cap_q;
  logic      cs_q;
  logic [2:0] bit_cnt;
  int        byte_idx;
  byte_t     mosi_sh, miso_sh;
  logic      is_wr;
  reg_addr_t addr;

  // Expected MISO byte for a read slot
  function automatic byte_t expected_read(input reg_addr_t a);
    if (a == STATUS_ADDR)
      return i_status;               // Live status, never stored
    return model[a];
  endfunction

  // Expected write event, valid drops for the status slot
  function automatic reg_wr_t expected_write(input reg_addr_t a, input byte_t d);
    reg_wr_t w;
    w.valid = (a != STATUS_ADDR);
    w.addr  = a;
    w.data  = d;
    return w;
  endfunction

  task automatic compare(input string what, input logic [12:0] exp_v, input logic [12:0] act_v);
    o_checks++;
    if (exp_v !== act_v)
    begin
      o_errors++;
      $display("[FAIL] %s %s: expected 0x%0h, actual 0x%0h", test_name, what, exp_v, act_v);
    end
  endtask

  always @(posedge i_Clk)
  begin
    logic     cap_now;
    byte_t    mosi_b;
    byte_t    miso_b;
    reg_wr_t  exp_w;
    spi_cmd_t cmd;
    cap_now = CAP_INV ? ~i_spi_clk : i_spi_clk;
    if (!i_rst_n)
    begin
      for (int i = 0; i < `SPI_REG_COUNT; i++)
        model[i] = '0;                                // Bank resets to zero
      exp_q.delete();
      cs_q     = 1'b1;
      o_frames = 0;
      o_checks = 0;
      o_errors = 0;
    end
    else
    begin
      if (cs_q && !i_spi_cs_n)                        // Frame start
      begin
        bit_cnt  = '0;
        byte_idx = 0;
      end
      // SCLK seen one cycle late, MOSI and MISO still hold the bit
      if (!i_spi_cs_n && cap_now && !cap_q)
      begin
        mosi_b  = {mosi_sh[6:0], i_spi_mosi};
        miso_b  = {miso_sh[6:0], i_spi_miso};
        mosi_sh = mosi_b;
        miso_sh = miso_b;
        bit_cnt = bit_cnt + 3'd1;
        if (bit_cnt == 3'd0)                          // Byte complete
        begin
          if (byte_idx == 0)
          begin
            cmd   = spi_cmd_t'(mosi_b);
            is_wr = cmd.wr;
            addr  = cmd.addr;
          end
          else if (is_wr)
          begin
            exp_w = expected_write(addr, mosi_b);
            if (exp_w.valid)
            begin
              exp_q.push_back(exp_w);
              model[addr] = mosi_b;
            end
            addr = addr + reg_addr_t'(1);             // Wraps 15 -> 0
          end
          else
          begin
            compare($sformatf("read 0x%0h", addr), 13'(expected_read(addr)), 13'(miso_b));
            addr = addr + reg_addr_t'(1);
          end
          byte_idx++;
        end
      end
      if (i_wr_evt.valid)
      begin
        if (exp_q.size() == 0)
        begin
          o_errors++;
          $display("Test %s: write event to 0x%0h with data 0x%0h was not expected",
                   test_name, i_wr_evt.addr, i_wr_evt.data);
        end
        else
        begin
          exp_w = exp_q.pop_front();
          compare("write event", exp_w, i_wr_evt);
        end
      end
      if (!cs_q && i_spi_cs_n)                        // Frame end
      begin
        if (exp_q.size() != 0)
        begin
          o_errors++;
          $display("Test %s: %0d write events never appeared", test_name, exp_q.size());
          exp_q.delete();
        end
        compare("ctrl", 13'(model[0]), 13'(i_ctrl));
        o_frames++;
      end
      cs_q = i_spi_cs_n;
    end
    cap_q = cap_now;
  end

endmodule

/* bench/spi_periph_tb.sv */
// SPI peripheral testbench
// SPI master drives register frames while the checker module judges every result
`timescale 1ns/1ps
`include "spi_macros.svh"

module spi_periph_tb
  import spi_pkg::*;
();

  localparam int   HALF_SCLK   = 8;                   // SCLK is i_Clk / 16
  localparam int   MAX_BYTES   = 200;                 // Upper bound on SPI bytes sent
  localparam int   CYCLE_LIMIT = MAX_BYTES * 16 * 16 + 4000;
  localparam int   BUF_LEN     = `SPI_REG_COUNT + 1;  // Command plus a full bank burst
  localparam logic CPOL        = (`SPI_MODE >= 2);
  localparam logic CPHA        = (`SPI_MODE == 1) || (`SPI_MODE == 3);

  logic    i_Clk;
  logic    i_rst_n;
  logic    spi_clk, spi_mosi, spi_cs_n, spi_miso;
  byte_t   status;
  byte_t   ctrl;
  reg_wr_t wr_evt;
  int      frames, checks, errors;                   // From the checker
  int      seed;
  int      frames_sent;
  int      cycle_cnt;
  int      tests_passed, tests_failed;
  int      err_before, chk_before;
  byte_t   tx_buf [BUF_LEN];                          // Command then data
  byte_t   rx_buf [BUF_LEN];                          // MISO per slot

  spi_periph_top uut (
    .i_Clk (i_Clk), .i_rst_n (i_rst_n),
    .i_spi_clk (spi_clk), .i_spi_mosi (spi_mosi), .i_spi_cs_n (spi_cs_n),
    .o_spi_miso (spi_miso), .i_status (status), .o_ctrl (ctrl), .o_wr_evt (wr_evt)
  );

  spi_periph_checker chk (
    .i_Clk (i_Clk), .i_rst_n (i_rst_n),
    .i_spi_clk (spi_clk), .i_spi_mosi (spi_mosi), .i_spi_miso (spi_miso),
    .i_spi_cs_n (spi_cs_n), .i_status (status), .i_ctrl (ctrl), .i_wr_evt (wr_evt),
    .o_frames (frames), .o_checks (checks), .o_errors (errors)
  );

  initial
  begin
    i_Clk = 1'b0;
    forever #5 i_Clk = ~i_Clk;
  end

  // Run limit from the byte budget
  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT)
    begin
      @(posedge i_Clk);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles, SPI traffic did not complete", cycle_cnt);
    $display("Simulation finished: FAIL");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // SPI master
  //////////////////////////////////////////////////////////////////////

  function automatic byte_t rand_byte();
    int r;
    r = $random(seed);
    return r[7:0];
  endfunction

  task automatic spi_byte(input byte_t tx, output byte_t rx);
    byte_t sh;
    sh = tx;
    rx = '0;
    for (int b = 0; b < 8; b++)
    begin
      @(posedge i_Clk);
      spi_clk  <= CPHA ? ~CPOL : CPOL;                // Launch edge or idle level for bit 7
      spi_mosi <= sh[7];                              // MSB first
      sh = {sh[6:0], 1'b0};
      repeat (HALF_SCLK) @(posedge i_Clk);
      rx = {rx[6:0], spi_miso};                       // Settled half a period ago
      spi_clk <= CPHA ? CPOL : ~CPOL;                 // Capture edge
      repeat (HALF_SCLK - 1) @(posedge i_Clk);
    end
  endtask

  // Sends tx_buf[0..n-1] in one chip select window
  task automatic spi_frame(input int n);
    byte_t rx;
    @(posedge i_Clk);
    spi_cs_n <= 1'b0;
    repeat (HALF_SCLK) @(posedge i_Clk);
    for (int i = 0; i < n; i++)
    begin
      spi_byte(tx_buf[i], rx);
      rx_buf[i] = rx;
    end
    @(posedge i_Clk);
    spi_clk <= CPOL;                                  // Closing edge back to idle
    repeat (HALF_SCLK) @(posedge i_Clk);
    spi_cs_n <= 1'b1;
    frames_sent++;
    wait (frames == frames_sent);                     // Checker closed the frame
    repeat (HALF_SCLK) @(posedge i_Clk);
  endtask

  task automatic run_frame(input logic wr, input reg_addr_t addr, input int n_data);
    tx_buf[0] = {wr, 3'b000, addr};                   // Command byte
    spi_frame(n_data + 1);
  endtask

  task automatic start_test(input string name);
    chk.test_name = name;
    err_before    = errors;
    chk_before    = checks;
  endtask

  task automatic end_test(input string name);
    if (errors == err_before)
    begin
      tests_passed++;
      $display("Test %s: ok, %0d checks", name, checks - chk_before);
    end
    else
    begin
      tests_failed++;
      $display("Test %s: %0d errors", name, errors - err_before);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    int r;
    seed = 69149;
    i_rst_n = 1'b0;
    spi_clk = CPOL;
    spi_mosi = 1'b0;
    spi_cs_n = 1'b1;
    status = 8'hA5;
    frames_sent = 0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (2) @(posedge i_Clk);
    i_rst_n <= 1'b1;
    repeat (4) @(posedge i_Clk);

    start_test("reset_state");
    run_frame(1'b0, 4'd0, 16);                        // All sixteen registers
    end_test("reset_state");

    start_test("single_write");
    tx_buf[1] = 8'h3C;
    run_frame(1'b1, 4'd3, 1);
    run_frame(1'b0, 4'd3, 1);
    end_test("single_write");

    start_test("burst_wrap");
    for (int i = 1; i < 6; i++)
      tx_buf[i] = rand_byte();
    run_frame(1'b1, 4'd13, 5);                        // Covers 13 14 15 0 1 with 15 dropped
    run_frame(1'b0, 4'd13, 5);
    end_test("burst_wrap");

    start_test("status_reg");
    @(posedge i_Clk);
    status <= 8'h5A;
    run_frame(1'b0, 4'd15, 1);
    tx_buf[1] = rand_byte();
    run_frame(1'b1, 4'd15, 1);                        // Dropped without an event
    run_frame(1'b0, 4'd15, 2);                        // Status then register 0
    @(posedge i_Clk);
    status <= rand_byte();
    run_frame(1'b0, 4'd15, 1);
    end_test("status_reg");

    start_test("random_frames");
    for (int f = 0; f < 20; f++)
    begin
      r = $random(seed);
      for (int i = 1; i < 8; i++)
        tx_buf[i] = rand_byte();
      run_frame(r[4], r[3:0], 1 + ((r >> 8) & 255) % 6);
    end
    end_test("random_frames");

    $display("Tests passed %0d, failed %0d, checks %0d, errors %0d",
             tests_passed, tests_failed, checks, errors);
    if (tests_failed == 0 && errors == 0 && checks > 0)
    begin
      $display("Simulation finished: PASS");
    end
    else
    begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* filelist.f */
+incdir+verilog
verilog/spi_pkg.sv
verilog/spi_slave.sv
verilog/spi_frame_decoder.sv
verilog/spi_reg_bank.sv
verilog/spi_periph_top.sv
bench/spi_periph_checker.sv
bench/spi_periph_tb.sv

/* verilog/spi_frame_decoder.sv */
// SPI frame decoder
// Parses the command byte, steps the address, issues writes and read loads
`timescale 1ns/1ps
`include "spi_macros.svh"

module spi_frame_decoder
  import spi_pkg::*;
(
  input  logic      i_Clk,
  input  logic      i_rst_n,
  // From the slave
  input  logic      i_rx_valid,
  input  byte_t     i_rx_byte,
  input  logic      i_frame_end,
  // To the slave
  output logic      o_tx_load,
  output byte_t     o_tx_byte,
  // Register bank
  output reg_wr_t   o_wr,
  output reg_addr_t o_rd_addr,
  input  byte_t     i_rd_data
);

  dec_state_e state;
  reg_addr_t  addr_q;         // Next address to write or to load
  spi_cmd_t   cmd;
  logic       wr_drop;        // Write aimed at the status slot

  // Only meaningful in DEC_CMD with i_rx_valid
  assign cmd = spi_cmd_t'(i_rx_byte);

  // Bank read port
  // Command cycle reads the start address straight off the byte
  assign o_rd_addr = (state == DEC_CMD) ? cmd.addr : addr_q;

  assign wr_drop = (addr_q == reg_addr_t'(`SPI_STATUS_ADDR));

  //////////////////////////////////////////////////////////////////////
  // Frame FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_Clk)
  begin
    if (!i_rst_n)
    begin
      state      <= DEC_CMD;
      addr_q     <= '0;
      o_tx_load  <= 1'b0;
      o_wr.valid <= 1'b0;
    end
    else
    begin
      o_tx_load  <= 1'b0;                           // Pulses by default
      o_wr.valid <= 1'b0;
      if (i_rx_valid)
      begin
        case (state)
          DEC_CMD:
          begin
            if (cmd.wr)
            begin
              state  <= DEC_WRITE;
              addr_q <= cmd.addr;                   // First data byte lands here
            end
            else
            begin
              state     <= DEC_READ;
              addr_q    <= cmd.addr + reg_addr_t'(1);
              o_tx_load <= 1'b1;                    // Start register for slot 2
            end
          end
          DEC_WRITE:
          begin
            o_wr.valid <= ~wr_drop;                 // Status writes vanish
            addr_q     <= addr_q + reg_addr_t'(1);  // Wraps 15 -> 0
          end
          DEC_READ:
          begin
            o_tx_load <= 1'b1;                      // Byte for the next slot
            addr_q    <= addr_q + reg_addr_t'(1);
          end
          default:
          begin
            state <= DEC_CMD;
          end
        endcase
      end
      // End of frame wins over any state change above
      if (i_frame_end)
      begin
        state <= DEC_CMD;
      end
    end

    // Payload, captured on every byte
    if (i_rx_valid)
    begin
      o_tx_byte <= i_rd_data;
      o_wr.addr <= addr_q;
      o_wr.data <= i_rx_byte;
    end
  end

endmodule

/* verilog/spi_macros.svh */
// SPI peripheral build constants
// Mode selection and register bank geometry
`ifndef SPI_MACROS_SVH
`define SPI_MACROS_SVH

// SPI mode 0..3, bit 1 is CPOL and bit 0 is CPHA
`define SPI_MODE 0

// Number of 8-bit registers behind the frame decoder
`define SPI_REG_COUNT 16

// Read-only slot that reflects the external status input
// Last address of the bank
`define SPI_STATUS_ADDR 15

`endif

/* verilog/spi_periph_top.sv */
// SPI register peripheral top level
// Serial engine, frame decoder and register bank
`timescale 1ns/1ps
`include "spi_macros.svh"

module spi_periph_top
  import spi_pkg::*;
(
  input  logic    i_Clk,
  input  logic    i_rst_n,
  // SPI pins
  input  logic    i_spi_clk,
  input  logic    i_spi_mosi,
  input  logic    i_spi_cs_n,
  output logic    o_spi_miso,
  // Register side pins
  input  byte_t   i_status,
  output byte_t   o_ctrl,
  output reg_wr_t o_wr_evt        // Accepted writes, status writes excluded
);

  // Slave <-> decoder
  logic      rx_valid;
  byte_t     rx_byte;
  logic      frame_end;
  logic      tx_load;
  byte_t     tx_byte;

  // Decoder <-> bank
  reg_wr_t   wr;
  reg_addr_t rd_addr;
  byte_t     rd_data;

  spi_slave #(
    .SPI_MODE    (`SPI_MODE)
  ) u_slave (
    .i_Clk       (i_Clk),
    .i_rst_n     (i_rst_n),
    .i_spi_clk   (i_spi_clk),
    .i_spi_mosi  (i_spi_mosi),
    .i_spi_cs_n  (i_spi_cs_n),
    .o_spi_miso  (o_spi_miso),
    .o_rx_valid  (rx_valid),
    .o_rx_byte   (rx_byte),
    .o_frame_end (frame_end),
    .i_tx_load   (tx_load),
    .i_tx_byte   (tx_byte)
  );

  spi_frame_decoder u_decoder (
    .i_Clk       (i_Clk),
    .i_rst_n     (i_rst_n),
    .i_rx_valid  (rx_valid),
    .i_rx_byte   (rx_byte),
    .i_frame_end (frame_end),
    .o_tx_load   (tx_load),
    .o_tx_byte   (tx_byte),
    .o_wr        (wr),
    .o_rd_addr   (rd_addr),
    .i_rd_data   (rd_data)
  );

  spi_reg_bank u_bank (
    .i_Clk       (i_Clk),
    .i_rst_n     (i_rst_n),
    .i_wr        (wr),
    .i_rd_addr   (rd_addr),
    .o_rd_data   (rd_data),
    .i_status    (i_status),
    .o_ctrl      (o_ctrl)
  );

  assign o_wr_evt = wr;           // Same strobe the bank sees

endmodule

/* verilog/spi_pkg.sv */
// SPI peripheral shared types
// Byte, address, command layout, register write and decoder states
package spi_pkg;

  // Plain data byte on the serial link and in the bank
  typedef logic [7:0] byte_t;

  // Register index, wraps from 15 back to 0
  typedef logic [3:0] reg_addr_t;

  // First byte of every frame
  typedef struct packed {
    logic       wr;       // 1 = write frame, 0 = read frame
    logic [2:0] rsvd;     // Ignored
    reg_addr_t  addr;     // Start address
  } spi_cmd_t;

  // Register write from the decoder, also the top level write event
  typedef struct packed {
    logic      valid;     // One-cycle strobe
    reg_addr_t addr;
    byte_t     data;
  } reg_wr_t;

  // Frame decoder FSM
  typedef enum logic [1:0] {
    DEC_CMD   = 2'd0,     // Waiting for command byte
    DEC_WRITE = 2'd1,     // Data bytes go into the bank
    DEC_READ  = 2'd2      // Data slots return bank contents
  } dec_state_e;

endpackage

/* verilog/spi_reg_bank.sv */
// SPI register bank
// Sixteen 8-bit registers, read-only status slot, register 0 drives control
`timescale 1ns/1ps
`include "spi_macros.svh"

module spi_reg_bank
  import spi_pkg::*;
(
  input  logic      i_Clk,
  input  logic      i_rst_n,
  // Write port from the decoder
  input  reg_wr_t   i_wr,
  // Combinational read port
  input  reg_addr_t i_rd_addr,
  output byte_t     o_rd_data,
  // External pins
  input  byte_t     i_status,
  output byte_t     o_ctrl
);

  localparam reg_addr_t STATUS_ADDR = reg_addr_t'(`SPI_STATUS_ADDR);

  byte_t regs [`SPI_REG_COUNT];
  logic  wr_en;
  logic  rd_status;

  //////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////

  // Status slot is never written
  assign wr_en = i_wr.valid && (i_wr.addr != STATUS_ADDR);

  always_ff @(posedge i_Clk)
  begin
    if (!i_rst_n)
    begin
      for (int i = 0; i < `SPI_REG_COUNT; i++)
      begin
        regs[i] <= '0;                              // Bank comes up zeroed
      end
    end
    else if (wr_en)
    begin
      regs[i_wr.addr] <= i_wr.data;                 // Visible on the next read
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read mux and control output
  //////////////////////////////////////////////////////////////////////

  assign rd_status = (i_rd_addr == STATUS_ADDR);

  // Status input is sampled live, no holding register
  assign o_rd_data = rd_status ? i_status : regs[i_rd_addr];

  assign o_ctrl = regs[0];                          // Control register

endmodule

/* verilog/spi_slave.sv */
// SPI slave byte engine
// Shifts bytes in on MOSI and out on MISO, hands them to i_Clk with frame end
`timescale 1ns/1ps
`include "spi_macros.svh"

module spi_slave
  import spi_pkg::*;
#(
  parameter int SPI_MODE = `SPI_MODE
)
(
  input  logic  i_Clk,
  input  logic  i_rst_n,
  // SPI pins
  input  logic  i_spi_clk,
  input  logic  i_spi_mosi,
  input  logic  i_spi_cs_n,          // Active low
  output logic  o_spi_miso,
  // i_Clk domain
  output logic  o_rx_valid,          // One-cycle pulse per received byte
  output byte_t o_rx_byte,
  output logic  o_frame_end,         // One-cycle pulse on chip select release
  input  logic  i_tx_load,
  input  byte_t i_tx_byte
);

  logic       cpol;                  // Clock idles high
  logic       cpha;                  // Capture on trailing edge
  logic       spi_clk_cap;           // Rises on the capture edge

  logic [2:0] rx_bit_cnt;
  byte_t      rx_shift;
  byte_t      rx_hold;               // Full byte, stable while rx_done is high
  logic       rx_done;
  logic       rx_done_q1, rx_done_q2;

  byte_t      tx_hold;               // Written in i_Clk, read in SPI domain
  logic [2:0] tx_bit_cnt;
  logic [2:0] tx_bit_nxt;
  logic       miso_bit;

  logic       cs_q1, cs_q2, cs_q3;   // Chip select synchronizer + edge stage

  assign cpol = (SPI_MODE == 2) || (SPI_MODE == 3);
  assign cpha = (SPI_MODE == 1) || (SPI_MODE == 3);

  // Capture edge is the rising SCLK edge when CPOL equals CPHA
  assign spi_clk_cap = (cpol ^ cpha) ? ~i_spi_clk : i_spi_clk;

  //////////////////////////////////////////////////////////////////////
  // SPI domain receive
  //////////////////////////////////////////////////////////////////////

  // Chip select high clears the bit position between frames
  always_ff @(posedge spi_clk_cap or posedge i_spi_cs_n)
  begin
    if (i_spi_cs_n)
    begin
      rx_bit_cnt <= 3'd0;
      rx_done    <= 1'b0;
    end
    else
    begin
      rx_bit_cnt <= rx_bit_cnt + 3'd1;
      rx_shift   <= {rx_shift[6:0], i_spi_mosi};    // MSB first
      if (rx_bit_cnt == 3'd7)
      begin
        rx_done <= 1'b1;
        rx_hold <= {rx_shift[6:0], i_spi_mosi};
      end
      else if (rx_bit_cnt == 3'd2)
      begin
        rx_done <= 1'b0;                            // Drop early in next byte
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Crossing into i_Clk
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_Clk)
  begin
    if (!i_rst_n)
    begin
      rx_done_q1  <= 1'b0;
      rx_done_q2  <= 1'b0;
      o_rx_valid  <= 1'b0;
      cs_q1       <= 1'b1;                          // Idle, no false frame end
      cs_q2       <= 1'b1;
      cs_q3       <= 1'b1;
      o_frame_end <= 1'b0;
      tx_hold     <= '0;                            // MISO sends zeros until a load
    end
    else
    begin
      rx_done_q1  <= rx_done;                       // Two-stage sync
      rx_done_q2  <= rx_done_q1;
      o_rx_valid  <= rx_done_q1 & ~rx_done_q2;      // Rising edge
      cs_q1       <= i_spi_cs_n;
      cs_q2       <= cs_q1;
      cs_q3       <= cs_q2;
      o_frame_end <= cs_q2 & ~cs_q3;                // Chip select released
      if (i_tx_load)
      begin
        tx_hold <= i_tx_byte;
      end
    end
    // rx_hold is stable for several SPI bits once rx_done is seen
    if (rx_done_q1 & ~rx_done_q2)
    begin
      o_rx_byte <= rx_hold;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // SPI domain transmit
  //////////////////////////////////////////////////////////////////////

  assign tx_bit_nxt = tx_bit_cnt - 3'd1;

  // Launch edge is opposite the capture edge
  // CPHA=0 presents bit 7 as soon as chip select drops
  // CPHA=1 launches bit 7 on the first leading edge instead
  always_ff @(negedge spi_clk_cap or posedge i_spi_cs_n)
  begin
    if (i_spi_cs_n)
    begin
      tx_bit_cnt <= cpha ? 3'd0 : 3'd7;
      miso_bit   <= tx_hold[7];
    end
    else
    begin
      tx_bit_cnt <= tx_bit_nxt;
      miso_bit   <= tx_hold[tx_bit_nxt];            // tx_hold crosses here
    end
  end

  assign o_spi_miso = miso_bit;                     // Always driven

endmodule
